// ==== design/mmu_pkg.sv ====
package mmu_pkg;

	// ==========================================================
	// Address geometry
	// ==========================================================

	typedef logic [31:0] virtual_address_t;
	typedef logic [31:0] physical_address_t;

	// Address space ID used to tag every TLB entry
	typedef logic [15:0] asid_t;

	// Default page size is 8 KB, so the low 13 bits are the page offset
	localparam int LOG_PAGESIZE_DEF = 13;

	// Width of a virtual or physical page number
	localparam int PN_W = 32 - LOG_PAGESIZE_DEF;

	// ==========================================================
	// Page table entry
	// ==========================================================

	// One 32-bit word of the single level page table
	typedef struct packed {
		logic            v;
		logic [PN_W-1:0] ppn;
		logic [11:0]     rsvd;
	} pte_t;

	// The walker receives a raw memory word and reads it back as fields
	typedef union packed {
		logic [31:0] raw;
		pte_t        pte;
	} pte_word_u;

	// ==========================================================
	// TLB entry
	// ==========================================================

	// Entry valid, tag (asid and vpn) and the translation itself
	typedef struct packed {
		logic            v;
		asid_t           asid;
		logic [PN_W-1:0] vpn;
		pte_t            pte;
	} tlb_entry_t;

endpackage

// ==== design/tlb_lookup_if.sv ====
`timescale 1ns/1ps

interface tlb_lookup_if #(
	parameter int TLB_ASSOC = 3
);

	// Lookup key, shared by all ways
	mmu_pkg::virtual_address_t vadr;
	mmu_pkg::asid_t asid;

	// One hit bit per way
	logic [TLB_ASSOC-1:0] hit;

	// Full content of every way, so the mux can pick the translation
	mmu_pkg::tlb_entry_t [TLB_ASSOC-1:0] tlbe;

	// The ways compare the key and present their entries
	modport ways (input vadr, input asid, output hit, output tlbe);

	// The mux only consumes the result of the compare
	modport mux (input hit, input tlbe);

endinterface

// ==== design/tlb_ways.sv ====
`timescale 1ns/1ps

module tlb_ways #(
	parameter int TLB_ASSOC = 3,
	parameter int LOG_PAGESIZE = 13
) (
	input logic clk,
	input logic rst,
	input logic fill_v,
	input mmu_pkg::tlb_entry_t fill_entry,
	tlb_lookup_if.ways lookup
);

	// Pointer width, kept at one bit even for a single way
	localparam int PTR_W = (TLB_ASSOC > 1) ? $clog2(TLB_ASSOC) : 1;
	localparam logic [PTR_W-1:0] LAST_WAY = PTR_W'(TLB_ASSOC - 1);

	mmu_pkg::tlb_entry_t entries [TLB_ASSOC];
	logic [PTR_W-1:0] victim;
	logic [31:0] page_bits;
	logic [mmu_pkg::PN_W-1:0] vpn;

	// ==========================================================
	// Key extraction
	// ==========================================================

	// Drop the page offset to get the virtual page number
	assign page_bits = lookup.vadr >> LOG_PAGESIZE;
	assign vpn = page_bits[mmu_pkg::PN_W-1:0];

	// ==========================================================
	// Storage and fill
	// ==========================================================

	// Only the valid bits need clearing at reset
	// The tag and translation are ignored while an entry is invalid
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < TLB_ASSOC; i++) begin
				entries[i].v <= 1'b0;
			end
		end else if (fill_v) begin
			entries[victim] <= fill_entry;
		end
	end

	// Round-robin victim choice
	// Every fill moves the pointer on by one way and wraps after the last
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= '0;
		end else if (fill_v) begin
			if (victim == LAST_WAY) begin
				victim <= '0;
			end else begin
				victim <= victim + 1'b1;
			end
		end
	end

	// ==========================================================
	// Parallel compare
	// ==========================================================

	// All ways are compared in the same cycle
	// A way hits when it is valid and both the page and the address space match
	always_comb begin
		for (int i = 0; i < TLB_ASSOC; i++) begin
			lookup.hit[i] = entries[i].v && (entries[i].vpn == vpn) &&
				(entries[i].asid == lookup.asid);
			lookup.tlbe[i] = entries[i];
		end
	end

	// The walker only fills on a miss, so a page can never sit in two ways
	// A second hit would mean the miss and fill timing between mux and walker broke
	a_single_hit: assert property (@(posedge clk) disable iff (rst)
		$onehot0(lookup.hit))
		else $error("tlb_ways: more than one way hits");

endmodule

// ==== design/tlb_adr_mux.sv ====
`timescale 1ns/1ps

module tlb_adr_mux #(
	parameter int TLB_ASSOC = 3,
	parameter int LOG_PAGESIZE = 13
) (
	input logic clk,
	input logic rst,
	input logic idle,
	input logic paging_en,
	input mmu_pkg::virtual_address_t vadr,
	input logic vadr_v,
	input mmu_pkg::asid_t asid,
	input logic [7:0] id,
	tlb_lookup_if.mux lookup,
	output mmu_pkg::physical_address_t padr,
	output logic padr_v,
	output logic tlb_v,
	output logic [7:0] miss_id,
	output mmu_pkg::virtual_address_t miss_adr,
	output mmu_pkg::asid_t miss_asid,
	output logic miss_v
);

	// Selects the page offset bits that pass through translation unchanged
	localparam logic [31:0] OFFSET_MASK = (32'd1 << LOG_PAGESIZE) - 32'd1;

	logic [31:0] page_bits;
	logic [mmu_pkg::PN_W-1:0] vpn;
	logic [mmu_pkg::PN_W-1:0] prev_vpn;
	logic page_chg;
	logic pe_q;
	logic pe_rise;
	logic any_hit;
	logic lookup_ok;
	logic miss_q;
	mmu_pkg::physical_address_t hit_adr;

	// ==========================================================
	// Change and edge detection
	// ==========================================================

	assign page_bits = vadr >> LOG_PAGESIZE;
	assign vpn = page_bits[mmu_pkg::PN_W-1:0];

	// The ways need a cycle to look up a new page
	// Until then a miss on the new page would be spurious
	always_ff @(posedge clk) begin
		if (rst) begin
			prev_vpn <= '0;
			pe_q <= 1'b0;
		end else begin
			prev_vpn <= vpn;
			pe_q <= paging_en;
		end
	end

	assign page_chg = (vpn != prev_vpn);

	// Translations are transient in the cycle paging turns on
	assign pe_rise = paging_en & ~pe_q;

	// ==========================================================
	// Way select
	// ==========================================================

	// At most one way hits, so the last match found is the only one
	always_comb begin
		hit_adr = '0;
		for (int i = 0; i < TLB_ASSOC; i++) begin
			if (lookup.hit[i]) begin
				hit_adr = (32'(lookup.tlbe[i].pte.ppn) << LOG_PAGESIZE) | (vadr & OFFSET_MASK);
			end
		end
	end

	assign any_hit = |lookup.hit;

	// A usable translation needs paging on, a hit, a valid access and a settled page
	assign lookup_ok = paging_en & any_hit & vadr_v & ~page_chg;

	// ==========================================================
	// Output registers
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			padr_v <= 1'b0;
			tlb_v <= 1'b0;
			miss_q <= 1'b0;
		end else if (paging_en) begin
			padr_v <= lookup_ok & ~pe_rise;
			// The hit is only reported once the walker has nothing in flight
			tlb_v <= lookup_ok & idle;
			miss_q <= vadr_v & ~page_chg & ~any_hit;
		end else begin
			padr_v <= 1'b0;
			tlb_v <= 1'b0;
			miss_q <= 1'b0;
		end
	end

	// With paging off the address goes through untranslated
	always_ff @(posedge clk) begin
		padr <= paging_en ? hit_adr : vadr;
	end

	// Miss details follow every failed lookup so the walker always sees the latest access
	always_ff @(posedge clk) begin
		if (paging_en && !lookup_ok) begin
			miss_adr <= vadr;
			miss_asid <= asid;
			miss_id <= id;
		end
	end

	// The miss drops as soon as a fill makes the page hit or the page moves on
	assign miss_v = miss_q & ~page_chg & ~any_hit;

	// A translation is never flagged valid right after paging was off
	a_no_valid_unpaged: assert property (@(posedge clk) disable iff (rst)
		padr_v |-> $past(paging_en))
		else $error("tlb_adr_mux: padr_v high after a cycle with paging off");

endmodule

// ==== design/tlb_miss_walker.sv ====
`timescale 1ns/1ps

module tlb_miss_walker #(
	parameter int LOG_PAGESIZE = 13,
	parameter logic [31:0] PT_BASE = 32'h0010_0000
) (
	input logic clk,
	input logic rst,
	input logic miss_v,
	input mmu_pkg::virtual_address_t miss_adr,
	input mmu_pkg::asid_t miss_asid,
	input logic pt_ack,
	input logic [31:0] pt_data,
	output logic idle,
	output logic pt_req,
	output logic [31:0] pt_adr,
	output logic fill_v,
	output mmu_pkg::tlb_entry_t fill_entry,
	output logic fault_v,
	output mmu_pkg::virtual_address_t fault_adr
);

	// State encoding
	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_REQUEST = 2'd1;
	localparam logic [1:0] ST_RELEASE = 2'd2;
	localparam logic [1:0] ST_FINISH  = 2'd3;

	logic [1:0] state;
	mmu_pkg::virtual_address_t adr_q;
	mmu_pkg::asid_t asid_q;
	mmu_pkg::pte_word_u pte_w;
	logic [31:0] page_bits;
	logic [mmu_pkg::PN_W-1:0] vpn;

	assign page_bits = adr_q >> LOG_PAGESIZE;
	assign vpn = page_bits[mmu_pkg::PN_W-1:0];

	// ==========================================================
	// Walk FSM
	// ==========================================================

	// The miss is latched on entry and held for the whole walk
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			pt_req <= 1'b0;
			fill_v <= 1'b0;
			fault_v <= 1'b0;
		end else begin
			fill_v <= 1'b0;
			fault_v <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (miss_v && idle) begin
						adr_q <= miss_adr;
						asid_q <= miss_asid;
						state <= ST_REQUEST;
					end
				end
				// Address is set up one cycle ahead and req raised with it
				ST_REQUEST: begin
					if (!pt_req) begin
						pt_adr <= PT_BASE + (32'(vpn) << 2);
						pt_req <= 1'b1;
					end else if (pt_ack) begin
						pte_w.raw <= pt_data;
						pt_req <= 1'b0;
						state <= ST_RELEASE;
					end
				end
				// No new request until the responder has let go of ack
				ST_RELEASE: begin
					if (!pt_ack) begin
						state <= ST_FINISH;
					end
				end
				ST_FINISH: begin
					if (pte_w.pte.v) begin
						fill_v <= 1'b1;
					end else begin
						fault_v <= 1'b1;
					end
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// While a fill or fault is still going out, the mux has not seen it yet
	// and its miss_v would start a second walk for the same page
	assign idle = (state == ST_IDLE) & ~fill_v & ~fault_v;

	// Latched tag and entry stay stable through the fill and fault pulses
	assign fill_entry = '{v: 1'b1, asid: asid_q, vpn: vpn, pte: pte_w.pte};
	assign fault_adr = adr_q;

	// Four-phase rules as seen from the requester side
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		$fell(pt_req) |-> $past(pt_ack))
		else $error("tlb_miss_walker: pt_req dropped before pt_ack");

	a_adr_stable: assert property (@(posedge clk) disable iff (rst)
		pt_req && $past(pt_req) |-> $stable(pt_adr))
		else $error("tlb_miss_walker: pt_adr changed during a request");

endmodule

// ==== design/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top #(
	parameter int TLB_ASSOC = 3,
	parameter int LOG_PAGESIZE = mmu_pkg::LOG_PAGESIZE_DEF,
	parameter logic [31:0] PT_BASE = 32'h0010_0000
) (
	input logic clk,
	input logic rst,
	input logic paging_en,
	input mmu_pkg::virtual_address_t vadr,
	input logic vadr_v,
	input mmu_pkg::asid_t asid,
	input logic [7:0] id,
	input logic pt_ack,
	input logic [31:0] pt_data,
	output mmu_pkg::physical_address_t padr,
	output logic padr_v,
	output logic tlb_v,
	output logic [7:0] miss_id,
	output logic pt_req,
	output logic [31:0] pt_adr,
	output logic fault_v,
	output mmu_pkg::virtual_address_t fault_adr
);

	// Miss path from mux to walker
	logic miss_v;
	mmu_pkg::virtual_address_t miss_adr;
	mmu_pkg::asid_t miss_asid;
	logic walker_idle;

	// Fill path from walker to ways
	logic fill_v;
	mmu_pkg::tlb_entry_t fill_entry;

	// ==========================================================
	// Lookup between ways and mux
	// ==========================================================

	tlb_lookup_if #(.TLB_ASSOC(TLB_ASSOC)) lookup ();

	assign lookup.vadr = vadr;
	assign lookup.asid = asid;

	tlb_ways #(
		.TLB_ASSOC(TLB_ASSOC),
		.LOG_PAGESIZE(LOG_PAGESIZE)
	) u_ways (
		.clk(clk),
		.rst(rst),
		.fill_v(fill_v),
		.fill_entry(fill_entry),
		.lookup(lookup.ways)
	);

	tlb_adr_mux #(
		.TLB_ASSOC(TLB_ASSOC),
		.LOG_PAGESIZE(LOG_PAGESIZE)
	) u_adr_mux (
		.clk(clk),
		.rst(rst),
		.idle(walker_idle),
		.paging_en(paging_en),
		.vadr(vadr),
		.vadr_v(vadr_v),
		.asid(asid),
		.id(id),
		.lookup(lookup.mux),
		.padr(padr),
		.padr_v(padr_v),
		.tlb_v(tlb_v),
		.miss_id(miss_id),
		.miss_adr(miss_adr),
		.miss_asid(miss_asid),
		.miss_v(miss_v)
	);

	// ==========================================================
	// Page table walk
	// ==========================================================

	tlb_miss_walker #(
		.LOG_PAGESIZE(LOG_PAGESIZE),
		.PT_BASE(PT_BASE)
	) u_walker (
		.clk(clk),
		.rst(rst),
		.miss_v(miss_v),
		.miss_adr(miss_adr),
		.miss_asid(miss_asid),
		.pt_ack(pt_ack),
		.pt_data(pt_data),
		.idle(walker_idle),
		.pt_req(pt_req),
		.pt_adr(pt_adr),
		.fill_v(fill_v),
		.fill_entry(fill_entry),
		.fault_v(fault_v),
		.fault_adr(fault_adr)
	);

endmodule

// ==== test/pt_responder.sv ====
`timescale 1ns/1ps

module pt_responder #(
	parameter logic [31:0] PT_BASE = 32'h0010_0000
) (
	input logic clk,
	input logic rst,
	input mmu_pkg::asid_t asid,
	input logic pt_req,
	input logic [31:0] pt_adr,
	output logic pt_ack,
	output logic [31:0] pt_data
);

	logic ack_q = 1'b0;
	logic [31:0] data_q = '0;
	logic pending = 1'b0;
	logic [2:0] wait_cycles = '0;

	assign pt_ack = ack_q;
	assign pt_data = data_q;

	// The table is never stored, every entry is built from its own address
	// ppn is the vpn xor the asid, and a vpn with bit 18 set is unmapped
	function automatic logic [31:0] pte_for_adr(input logic [31:0] adr, input mmu_pkg::asid_t as);
		logic [31:0] index;
		logic [18:0] vpn;
		mmu_pkg::pte_t pte;
		index = (adr - PT_BASE) >> 2;
		vpn = index[18:0];
		pte.v = ~vpn[18];
		pte.ppn = vpn ^ {3'b000, as};
		pte.rsvd = '0;
		return pte;
	endfunction

	// Four-phase slave side with a random 1 to 4 cycle wait before ack
	always @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			pending <= 1'b0;
			wait_cycles <= '0;
		end else if (ack_q) begin
			// Ack stays up until the walker has released its request
			if (!pt_req) begin
				ack_q <= 1'b0;
			end
		end else if (pending) begin
			if (wait_cycles == 3'd0) begin
				data_q <= pte_for_adr(pt_adr, asid);
				ack_q <= 1'b1;
				pending <= 1'b0;
			end else begin
				wait_cycles <= wait_cycles - 3'd1;
			end
		end else if (pt_req) begin
			pending <= 1'b1;
			wait_cycles <= 3'($urandom % 4);
		end
	end

endmodule

// ==== test/tb_mmu.sv ====
`timescale 1ns/1ps

module tb_mmu;

	localparam int TLB_ASSOC = 3;
	localparam int LOG_PAGESIZE = mmu_pkg::LOG_PAGESIZE_DEF;
	localparam logic [31:0] PT_BASE = 32'h0010_0000;
	localparam logic [31:0] SEED = 32'hc2655c7a;
	localparam logic [31:0] OFFSET_MASK = (32'd1 << LOG_PAGESIZE) - 32'd1;
	// A walk needs at most about 15 cycles and the run makes about a dozen of them
	// Reset, pass-through and cached offsets add under 50 cycles, so 4000 is ample
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] PAGE_A = 32'h0004_6000;
	localparam logic [31:0] FAULT_ADR = 32'h8012_3456;
	localparam logic [31:0] RR_BASE = 32'h0040_0000;
	localparam logic [15:0] ASID_A = 16'h1234;
	localparam logic [15:0] ASID_B = 16'h0a5c;

	logic clk = 1'b0;
	logic rst;
	logic paging_en;
	mmu_pkg::virtual_address_t vadr;
	logic vadr_v;
	mmu_pkg::asid_t asid;
	logic [7:0] id;
	logic pt_ack;
	logic [31:0] pt_data;
	mmu_pkg::physical_address_t padr;
	logic padr_v;
	logic tlb_v;
	logic [7:0] miss_id;
	logic pt_req;
	logic [31:0] pt_adr;
	logic fault_v;
	mmu_pkg::virtual_address_t fault_adr;

	// Inputs of the previous cycle, which the registered outputs answer to
	mmu_pkg::virtual_address_t prev_vadr;
	mmu_pkg::asid_t prev_asid;
	logic prev_paging_en = 1'b0;
	logic in_cached = 1'b0;
	logic cached_q = 1'b0;
	logic req_q = 1'b0;
	int walk_count = 0;
	int cycle_count = 0;
	int value_errors = 0;
	int event_errors = 0;
	string test_name = "reset";

	always #20 clk = ~clk;

	mmu_top #(.TLB_ASSOC(TLB_ASSOC), .LOG_PAGESIZE(LOG_PAGESIZE), .PT_BASE(PT_BASE)) UUT (.*);

	pt_responder #(.PT_BASE(PT_BASE)) u_responder (.*);

	// ============================================================
	// Page table rule
	// ============================================================

	function automatic logic [18:0] page_of(input logic [31:0] adr);
		logic [31:0] shifted;
		shifted = adr >> LOG_PAGESIZE;
		return shifted[18:0];
	endfunction

	// The ppn is the vpn xor the asid and the offset passes through
	function automatic logic [31:0] expected_padr(input logic [31:0] adr, input mmu_pkg::asid_t as);
		logic [18:0] ppn;
		ppn = page_of(adr) ^ {3'b000, as};
		return ({13'd0, ppn} << LOG_PAGESIZE) | (adr & OFFSET_MASK);
	endfunction

	always @(posedge clk) begin
		prev_vadr <= vadr;
		prev_asid <= asid;
		prev_paging_en <= paging_en;
		cached_q <= in_cached;
		req_q <= pt_req;
		cycle_count <= cycle_count + 1;
		// Every rising request is one page table walk
		if (pt_req && !req_q) begin
			walk_count <= walk_count + 1;
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	paging_off_check: assert property (@(posedge clk) disable iff (rst)
		!prev_paging_en |-> padr == prev_vadr && !padr_v)
		else begin
			value_errors++;
			$display("[ERROR] %s: expected padr %h valid 0, got padr %h valid %b",
				test_name, prev_vadr, padr, padr_v);
		end

	translate_check: assert property (@(posedge clk) disable iff (rst)
		padr_v |-> padr == expected_padr(prev_vadr, prev_asid))
		else begin
			value_errors++;
			$display("[ERROR] %s: expected padr %h, got %h", test_name,
				expected_padr(prev_vadr, prev_asid), padr);
		end

	// Pages with vpn bit 18 set are unmapped and must never translate
	unmapped_check: assert property (@(posedge clk) disable iff (rst)
		padr_v |-> page_of(prev_vadr) < 19'h4_0000)
		else begin
			event_errors++;
			$display("%s: padr_v rose for the unmapped address %h", test_name, prev_vadr);
		end

	walk_adr_check: assert property (@(posedge clk) disable iff (rst)
		pt_req |-> pt_adr == PT_BASE + {11'd0, page_of(vadr), 2'b00})
		else begin
			value_errors++;
			$display("[ERROR] %s: expected pt_adr %h, got %h", test_name,
				PT_BASE + {11'd0, page_of(vadr), 2'b00}, pt_adr);
		end

	fault_adr_check: assert property (@(posedge clk) disable iff (rst)
		fault_v |-> fault_adr == vadr)
		else begin
			value_errors++;
			$display("[ERROR] %s: expected fault_adr %h, got %h", test_name, vadr, fault_adr);
		end

	// The miss carries the id of the access that is being walked
	miss_id_check: assert property (@(posedge clk) disable iff (rst)
		(pt_req || fault_v) |-> miss_id == id)
		else begin
			value_errors++;
			$display("[ERROR] %s: expected miss_id %h, got %h", test_name, id, miss_id);
		end

	// A cached page answers one cycle after every access and never walks
	cached_check: assert property (@(posedge clk) disable iff (rst)
		cached_q |-> padr_v && !pt_req)
		else begin
			value_errors++;
			$display("[ERROR] %s: expected padr_v 1 pt_req 0, got padr_v %b pt_req %b",
				test_name, padr_v, pt_req);
		end

	// The hit flag is up for cached accesses and down while a walk is running
	hit_flag_check: assert property (@(posedge clk) disable iff (rst)
		(cached_q || pt_req) |-> tlb_v == cached_q)
		else begin
			value_errors++;
			$display("[ERROR] %s: expected tlb_v %b, got %b", test_name, cached_q, tlb_v);
		end

	// ============================================================
	// Stimulus
	// ============================================================

	// Present one access and wait until it translates or faults
	task automatic access_page(input string name, input logic [31:0] adr,
			input mmu_pkg::asid_t as, input logic want_walk, input logic want_fault);
		int walks_before;
		logic got_fault;
		test_name = name;
		walks_before = walk_count;
		vadr <= adr;
		asid <= as;
		vadr_v <= 1'b1;
		id <= id + 8'd1;
		in_cached <= 1'b0;
		// The first edge still shows the answer to the previous access
		@(posedge clk);
		do begin
			@(posedge clk);
		end while (!padr_v && !fault_v);
		got_fault = fault_v;
		assert (got_fault == want_fault) else begin
			value_errors++;
			$display("[ERROR] %s: expected fault %0b, got %0b", name, want_fault, got_fault);
		end
		assert ((walk_count != walks_before) == want_walk) else begin
			value_errors++;
			$display("[ERROR] %s: expected walk %0b, got %0b", name, want_walk,
				walk_count != walks_before);
		end
	endtask

	task automatic report_and_finish();
		$display("Errors: %0d wrong values, %0d missing or unexpected events",
			value_errors, event_errors);
		if (value_errors == 0 && event_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		paging_en = 1'b0;
		vadr = '0;
		vadr_v = 1'b0;
		asid = '0;
		id = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// With paging off the address passes through one cycle later
		test_name = "paging_off";
		for (int i = 0; i < 12; i++) begin
			vadr <= $urandom;
			vadr_v <= 1'b1;
			@(posedge clk);
		end

		paging_en <= 1'b1;
		access_page("first_walk", PAGE_A | 32'h0123, ASID_A, 1'b1, 1'b0);

		// Random offsets inside the page that is now cached
		test_name = "cached_offsets";
		in_cached <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			vadr <= PAGE_A | ($urandom & OFFSET_MASK);
			@(posedge clk);
		end

		access_page("asid_switch", PAGE_A | 32'h0040, ASID_B, 1'b1, 1'b0);
		access_page("asid_switch", PAGE_A | 32'h0044, ASID_A, 1'b0, 1'b0);
		access_page("page_fault", FAULT_ADR, ASID_A, 1'b1, 1'b1);

		// One page more than there are ways pushes the first one out
		for (int k = 0; k <= TLB_ASSOC; k++) begin
			access_page("replacement", RR_BASE + (32'(k) << LOG_PAGESIZE) + 32'h0008,
				ASID_A, 1'b1, 1'b0);
		end
		access_page("replacement", RR_BASE + 32'h0010, ASID_A, 1'b1, 1'b0);

		report_and_finish();
	end

	initial begin
		wait (cycle_count >= MAX_CYCLES);
		event_errors++;
		$display("Cycle limit of %0d reached before the tests finished", MAX_CYCLES);
		report_and_finish();
	end

endmodule

// ==== compile.f ====
design/mmu_pkg.sv
design/tlb_lookup_if.sv
design/tlb_ways.sv
design/tlb_adr_mux.sv
design/tlb_miss_walker.sv
design/mmu_top.sv
test/pt_responder.sv
test/tb_mmu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MMU testbench with Verilator, run it and judge the result from the log
verilator --binary --timing --assert -f compile.f --top-module tb_mmu -o tb_mmu &&
	./obj_dir/tb_mmu > sim.log 2>&1 || { echo "Build or simulation run failed"; exit 1; }
cat sim.log
! grep -q "Some tests failed" sim.log && grep -q "All tests passed" sim.log &&
	echo "PASS" || { echo "FAIL"; exit 1; }
